// ==== dv/dram_traffic_checker.sv ====
`timescale 1ns/1ps

module dram_traffic_checker (
    input logic                         clk_dram_ctrl,
    input logic                         rst_dram_ctrl,
    input logic                         o_mem_stb,
    input logic                         o_mem_we,
    input logic                         i_mem_stall,
    input logic                         o_wr_ready,
    input logic                         o_rd_addr_ready,
    input logic                         o_rd_data_valid,
    input logic                         i_rd_data_ready,
    input dram_traffic_pkg::line_data_t o_rd_data,
    input logic                         o_load_complete
);

    int fail_count = 0;  // assertion failures so far

    // writes only while loading, reads only once playing
    a_we_phase: assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        o_mem_stb |-> (o_mem_we == !o_load_complete))
        else begin
            $error("memory request with we in the wrong phase");
            fail_count++;
        end

    a_ready_stall: assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        i_mem_stall |-> (!o_wr_ready && !o_rd_addr_ready))
        else begin
            $error("stream ready high while the controller stalls");
            fail_count++;
        end

    // held line must not change under back-pressure
    a_rd_stable: assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        (o_rd_data_valid && !i_rd_data_ready) |=> (o_rd_data_valid && $stable(o_rd_data)))
        else begin
            $error("read data changed or dropped while stalled");
            fail_count++;
        end

endmodule

bind dram_traffic_top dram_traffic_checker checker_i (.*);

// ==== dv/tb_dram_memory.sv ====
`timescale 1ns/1ps

module tb_dram_memory #(
    parameter int SEED = 65
) (
    input  logic                         clk_dram_ctrl,
    input  logic                         rst_dram_ctrl,
    input  logic                         i_mem_stb,
    input  logic                         i_mem_we,
    input  dram_traffic_pkg::line_addr_t i_mem_addr,
    input  dram_traffic_pkg::line_data_t i_mem_wdata,
    output logic                         o_mem_stall,
    output logic                         o_mem_ack,
    output dram_traffic_pkg::line_data_t o_mem_rdata
);

    dram_traffic_pkg::line_data_t store [dram_traffic_pkg::line_addr_t];  // sparse
    int unsigned                  due_q[$];   // cycle each ack goes out
    dram_traffic_pkg::line_addr_t addr_q[$];
    logic                         we_q[$];
    int unsigned                  cycle = 0;
    int unsigned                  last_due = 0;
    int unsigned                  due;
    int                           seed;
    logic                         ack_next;
    dram_traffic_pkg::line_data_t rdata_next;

    initial begin
        seed        = SEED;
        o_mem_stall = 1'b0;
        o_mem_ack   = 1'b0;
        o_mem_rdata = '0;
    end

    always @(posedge clk_dram_ctrl) begin
        cycle++;
        ack_next   = 1'b0;
        rdata_next = '0;
        if (!rst_dram_ctrl && i_mem_stb && !o_mem_stall) begin
            if (i_mem_we) begin
                store[i_mem_addr] = i_mem_wdata;
            end
            due = cycle + $unsigned($random(seed)) % 3;  // ack 1 to 3 cycles out
            if (due <= last_due) begin
                due = last_due + 1;  // keep request order
            end
            last_due = due;
            due_q.push_back(due);
            addr_q.push_back(i_mem_addr);
            we_q.push_back(i_mem_we);
        end
        if (due_q.size() > 0 && due_q[0] <= cycle) begin
            ack_next = 1'b1;
            if (!we_q[0] && store.exists(addr_q[0])) begin
                rdata_next = store[addr_q[0]];
            end
            void'(due_q.pop_front());
            void'(addr_q.pop_front());
            void'(we_q.pop_front());
        end
        #1;
        o_mem_ack   = ack_next;
        o_mem_rdata = rdata_next;
        o_mem_stall = !rst_dram_ctrl && ($unsigned($random(seed)) % 4 == 0);
    end

endmodule

// ==== dv/tb_dram_traffic.sv ====
`timescale 1ns/1ps

module tb_dram_traffic;

    localparam int RETURN_DEPTH   = 4;
    localparam int N_LOAD         = 32;
    localparam int N_READ         = 64;
    localparam int TIMEOUT_CYCLES = 40 * (N_LOAD + N_READ) + 200;

    logic clk_dram_ctrl = 1'b0;
    logic rst_dram_ctrl;
    logic i_wr_valid;
    logic i_wr_last;
    dram_traffic_pkg::line_data_t i_wr_data;
    logic i_rd_addr_valid;
    dram_traffic_pkg::line_addr_t i_rd_addr;
    logic i_rd_data_ready;
    logic o_wr_ready;
    logic o_rd_addr_ready;
    logic o_rd_data_valid;
    dram_traffic_pkg::line_data_t o_rd_data;
    logic o_mem_stb;
    logic o_mem_we;
    dram_traffic_pkg::line_addr_t o_mem_addr;
    dram_traffic_pkg::line_data_t o_mem_wdata;
    logic i_mem_stall;
    logic i_mem_ack;
    dram_traffic_pkg::line_data_t i_mem_rdata;
    logic o_load_complete;

    dram_traffic_pkg::line_data_t model_mem [N_LOAD];  // lines as written
    dram_traffic_pkg::line_data_t expect_q[$];         // expected data of reads in flight
    int seed = 65;
    int ready_seed;
    int value_errors = 0;
    int other_errors = 0;
    int n_wr_acc = 0;
    int n_acks = 0;
    int n_rd_acc = 0;
    int n_rd_done = 0;
    int cycles = 0;
    logic load_seen = 1'b0;

    always #10 clk_dram_ctrl = ~clk_dram_ctrl;

    dram_traffic_top #(.RETURN_DEPTH(RETURN_DEPTH)) dut_i (.*);
    tb_dram_memory #(.SEED(65)) mem_i (
        .clk_dram_ctrl(clk_dram_ctrl),
        .rst_dram_ctrl(rst_dram_ctrl),
        .i_mem_stb(o_mem_stb),
        .i_mem_we(o_mem_we),
        .i_mem_addr(o_mem_addr),
        .i_mem_wdata(o_mem_wdata),
        .o_mem_stall(i_mem_stall),
        .o_mem_ack(i_mem_ack),
        .o_mem_rdata(i_mem_rdata)
    );

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_addr(input string name, input dram_traffic_pkg::line_addr_t got,
                              input dram_traffic_pkg::line_addr_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_data(input string name, input dram_traffic_pkg::line_data_t got,
                              input dram_traffic_pkg::line_data_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    // bus monitor and reference model sampled on the rising edge
    always @(posedge clk_dram_ctrl) begin
        if (!rst_dram_ctrl) begin
            if (n_acks < N_LOAD) begin
                check_bit("o_load_complete", o_load_complete, 1'b0);
                check_bit("o_rd_addr_ready", o_rd_addr_ready, 1'b0);
            end
            if (load_seen) check_bit("o_load_complete", o_load_complete, 1'b1);  // sticky
            load_seen = load_seen || o_load_complete;
            if (n_wr_acc == N_LOAD) begin
                check_bit("o_wr_ready", o_wr_ready, 1'b0);  // no writes after the last line
            end
            if (i_mem_ack) n_acks++;
            if (i_wr_valid && o_wr_ready) begin
                check_bit("o_mem_stb", o_mem_stb, 1'b1);
                check_bit("o_mem_we", o_mem_we, 1'b1);
                check_addr("o_mem_addr", o_mem_addr, dram_traffic_pkg::line_addr_t'(n_wr_acc));
                check_data("o_mem_wdata", o_mem_wdata, i_wr_data);
                model_mem[n_wr_acc % N_LOAD] = i_wr_data;
                n_wr_acc++;
            end
            if (i_rd_addr_valid && o_rd_addr_ready) begin
                check_bit("o_mem_stb", o_mem_stb, 1'b1);
                check_bit("o_mem_we", o_mem_we, 1'b0);
                check_addr("o_mem_addr", o_mem_addr, i_rd_addr);
                expect_q.push_back(model_mem[int'(i_rd_addr) % N_LOAD]);
                n_rd_acc++;
            end
            if (o_rd_data_valid && i_rd_data_ready) begin
                if (expect_q.size() == 0) begin
                    $display("%0t read data delivered with no read outstanding", $time);
                    other_errors++;
                end else begin
                    check_data("o_rd_data", o_rd_data, expect_q.pop_front());
                end
                n_rd_done++;
            end
            if (n_rd_acc - n_rd_done > RETURN_DEPTH) begin
                $display("%0t more reads outstanding than the return buffer holds", $time);
                other_errors++;
            end
        end
    end

    initial begin : timeout_watch
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_dram_ctrl);
            cycles++;
        end
        $display("timeout after %0d cycles, %0d of %0d reads returned", cycles, n_rd_done,
                 N_READ);
        $display("Testbench failed");
        $finish;
    end

    // long random stretches of back-pressure on the read-data stream
    initial begin : ready_toggle
        int hold;
        @(negedge rst_dram_ctrl);
        forever begin
            hold = 1 + $unsigned($random(ready_seed)) % 20;
            repeat (hold) @(posedge clk_dram_ctrl);
            #1 i_rd_data_ready = 1'($random(ready_seed));
        end
    end

    initial begin : stimulus
        int total;
        rst_dram_ctrl   = 1'b1;
        i_wr_valid      = 1'b0;
        i_wr_last       = 1'b0;
        i_wr_data       = '0;
        i_rd_addr_valid = 1'b0;
        i_rd_addr       = '0;
        i_rd_data_ready = 1'b0;
        ready_seed      = seed + 1;
        repeat (16) @(posedge clk_dram_ctrl);
        #1 rst_dram_ctrl = 1'b0;
        check_bit("o_mem_stb", o_mem_stb, 1'b0);
        check_bit("o_load_complete", o_load_complete, 1'b0);
        check_bit("o_rd_data_valid", o_rd_data_valid, 1'b0);

        for (int n = 0; n < N_LOAD; n++) begin
            i_wr_valid = 1'b1;
            i_wr_data  = {$random(seed), $random(seed), $random(seed), $random(seed)};
            i_wr_last  = (n == N_LOAD - 1);
            @(posedge clk_dram_ctrl);
            while (!o_wr_ready) @(posedge clk_dram_ctrl);
            #1 i_wr_valid = 1'b0;
            i_wr_last = 1'b0;
            repeat ($unsigned($random(seed)) % 3) @(posedge clk_dram_ctrl);
            #1;
        end

        while (!o_load_complete) @(posedge clk_dram_ctrl);
        #1;
        for (int n = 0; n < N_READ; n++) begin
            i_rd_addr_valid = 1'b1;
            i_rd_addr = dram_traffic_pkg::line_addr_t'($unsigned($random(seed)) % N_LOAD);
            @(posedge clk_dram_ctrl);
            while (!o_rd_addr_ready) @(posedge clk_dram_ctrl);
            #1 i_rd_addr_valid = 1'b0;
            repeat ($unsigned($random(seed)) % 2) @(posedge clk_dram_ctrl);
            #1;
        end

        while (n_rd_done < N_READ) @(posedge clk_dram_ctrl);
        repeat (4) @(posedge clk_dram_ctrl);
        if (expect_q.size() != 0) begin
            $display("%0d reads never returned their data", expect_q.size());
            other_errors++;
        end
        check_bit("o_rd_data_valid", o_rd_data_valid, 1'b0);  // nothing left over
        total = value_errors + other_errors + dut_i.checker_i.fail_count;
        $display("errors: %0d value, %0d protocol, %0d assertion", value_errors, other_errors,
                 dut_i.checker_i.fail_count);
        if (total == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== logic/dram_traffic_pkg.sv ====
package dram_traffic_pkg;

    // controller line address in burst-addressable {row, bank, col} order
    typedef logic [23:0] line_addr_t;

    // one controller beat of 8 x 16 pins
    typedef logic [127:0] line_data_t;

    // arbiter phases
    typedef enum logic [1:0] {
        ST_LOAD  = 2'd0,  // sample lines going in
        ST_DRAIN = 2'd1,  // last line taken and write acks pending
        ST_PLAY  = 2'd2   // audio reads only
    } traffic_state_t;

    // lines held for the read-data stream
    localparam int RETURN_DEPTH_DEFAULT = 4;

    // width of the unacked write count
    // controller acks land a few cycles after the request,
    // so a handful of writes in flight is the most we expect
    localparam int PENDING_W = 4;

endpackage

// ==== logic/dram_traffic_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dram_traffic_top #(
    parameter int RETURN_DEPTH = dram_traffic_pkg::RETURN_DEPTH_DEFAULT
) (
    input  wire                           clk_dram_ctrl,
    input  wire                           rst_dram_ctrl,

    // sample write stream
    input  wire                           i_wr_valid,
    output logic                          o_wr_ready,
    input  wire dram_traffic_pkg::line_data_t i_wr_data,
    input  wire                           i_wr_last,

    // audio read-address stream
    input  wire                           i_rd_addr_valid,
    output logic                          o_rd_addr_ready,
    input  wire dram_traffic_pkg::line_addr_t i_rd_addr,

    // read-data stream back out
    output logic                          o_rd_data_valid,
    input  wire                           i_rd_data_ready,
    output dram_traffic_pkg::line_data_t  o_rd_data,

    // controller request port
    output logic                          o_mem_stb,
    output logic                          o_mem_we,
    output dram_traffic_pkg::line_addr_t  o_mem_addr,
    output dram_traffic_pkg::line_data_t  o_mem_wdata,
    input  wire                           i_mem_stall,
    input  wire                           i_mem_ack,
    input  wire dram_traffic_pkg::line_data_t i_mem_rdata,

    output logic                          o_load_complete
);

    dram_traffic_pkg::line_addr_t wr_addr;
    logic writes_drained;
    logic has_space;
    logic wr_accept;
    logic wr_last_accept;
    logic rd_issue;

    // a stream beat and its memory request are the same event
    assign wr_accept      = i_wr_valid && o_wr_ready;
    assign wr_last_accept = wr_accept && i_wr_last;
    assign rd_issue       = i_rd_addr_valid && o_rd_addr_ready;

    traffic_fsm #(
        .RETURN_DEPTH(RETURN_DEPTH)
    ) fsm_i (
        .clk_dram_ctrl(clk_dram_ctrl),
        .rst_dram_ctrl(rst_dram_ctrl),
        .i_wr_valid(i_wr_valid),
        .i_wr_last(i_wr_last),
        .i_wr_data(i_wr_data),
        .i_wr_addr(wr_addr),
        .i_rd_addr_valid(i_rd_addr_valid),
        .i_rd_addr(i_rd_addr),
        .i_mem_stall(i_mem_stall),
        .i_writes_drained(writes_drained),
        .i_has_space(has_space),
        .o_wr_ready(o_wr_ready),
        .o_rd_addr_ready(o_rd_addr_ready),
        .o_mem_stb(o_mem_stb),
        .o_mem_we(o_mem_we),
        .o_mem_addr(o_mem_addr),
        .o_mem_wdata(o_mem_wdata),
        .o_load_complete(o_load_complete)
    );

    load_addr_counter addr_cnt_i (
        .clk_dram_ctrl(clk_dram_ctrl),
        .rst_dram_ctrl(rst_dram_ctrl),
        .i_wr_accept(wr_accept),
        .i_wr_last_accept(wr_last_accept),
        .i_mem_ack(i_mem_ack),
        .o_wr_addr(wr_addr),
        .o_writes_drained(writes_drained)
    );

    read_return_buffer #(
        .RETURN_DEPTH(RETURN_DEPTH)
    ) ret_buf_i (
        .clk_dram_ctrl(clk_dram_ctrl),
        .rst_dram_ctrl(rst_dram_ctrl),
        .i_rd_issue(rd_issue),
        .i_mem_ack(i_mem_ack),
        .i_mem_rdata(i_mem_rdata),
        .i_load_complete(o_load_complete),
        .o_has_space(has_space),
        .o_rd_data_valid(o_rd_data_valid),
        .o_rd_data(o_rd_data),
        .i_rd_data_ready(i_rd_data_ready)
    );

endmodule
`default_nettype wire

// ==== logic/load_addr_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_addr_counter (
    input  wire                          clk_dram_ctrl,
    input  wire                          rst_dram_ctrl,
    input  wire                          i_wr_accept,
    input  wire                          i_wr_last_accept,
    input  wire                          i_mem_ack,
    output dram_traffic_pkg::line_addr_t o_wr_addr,
    output logic                         o_writes_drained
);

    logic [dram_traffic_pkg::PENDING_W-1:0] pending;  // writes not yet acked
    logic last_seen;

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            o_wr_addr <= '0;
            pending   <= '0;
            last_seen <= 1'b0;
        end else begin
            if (i_wr_accept) begin
                o_wr_addr <= o_wr_addr + 1'b1;
            end
            if (i_wr_accept && !i_mem_ack) begin
                pending <= pending + 1'b1;
            end else if (!i_wr_accept && i_mem_ack && pending != '0) begin
                pending <= pending - 1'b1;  // floor at zero once reads start
            end
            if (i_wr_last_accept) begin
                last_seen <= 1'b1;
            end
        end
    end

    assign o_writes_drained = last_seen && (pending == '0);

endmodule
`default_nettype wire

// ==== logic/read_return_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module read_return_buffer #(
    parameter int RETURN_DEPTH = dram_traffic_pkg::RETURN_DEPTH_DEFAULT
) (
    input  wire                           clk_dram_ctrl,
    input  wire                           rst_dram_ctrl,
    input  wire                           i_rd_issue,
    input  wire                           i_mem_ack,
    input  wire dram_traffic_pkg::line_data_t i_mem_rdata,
    input  wire                           i_load_complete,
    output logic                          o_has_space,
    output logic                          o_rd_data_valid,
    output dram_traffic_pkg::line_data_t  o_rd_data,
    input  wire                           i_rd_data_ready
);

    localparam int PTR_W = (RETURN_DEPTH > 1) ? $clog2(RETURN_DEPTH) : 1;
    localparam int CNT_W = $clog2(RETURN_DEPTH + 1);

    dram_traffic_pkg::line_data_t mem [RETURN_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill;       // lines stored
    logic [CNT_W-1:0] in_flight;  // reads issued, data not back yet
    logic [CNT_W:0]   credit_used;
    logic push;
    logic pop;

    // load acks carry no data worth keeping
    assign push = i_mem_ack && i_load_complete;
    assign pop  = o_rd_data_valid && i_rd_data_ready;

    always_ff @(posedge clk_dram_ctrl) begin
        if (push) begin
            mem[wr_ptr] <= i_mem_rdata;
        end
    end

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            fill      <= '0;
            in_flight <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(RETURN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(RETURN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                fill <= fill + 1'b1;
            end else if (pop && !push) begin
                fill <= fill - 1'b1;
            end
            if (i_rd_issue && !push) begin
                in_flight <= in_flight + 1'b1;
            end else if (push && !i_rd_issue) begin
                in_flight <= in_flight - 1'b1;  // moved into storage
            end
        end
    end

    // a slot is reserved at issue, so a returning line always fits
    assign credit_used = {1'b0, fill} + {1'b0, in_flight};
    assign o_has_space = credit_used < (CNT_W + 1)'(RETURN_DEPTH);

    assign o_rd_data_valid = (fill != '0);
    assign o_rd_data       = mem[rd_ptr];

endmodule
`default_nettype wire

// ==== logic/traffic_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module traffic_fsm #(
    parameter int RETURN_DEPTH = dram_traffic_pkg::RETURN_DEPTH_DEFAULT
) (
    input  wire                           clk_dram_ctrl,
    input  wire                           rst_dram_ctrl,

    input  wire                           i_wr_valid,
    input  wire                           i_wr_last,
    input  wire dram_traffic_pkg::line_data_t i_wr_data,
    input  wire dram_traffic_pkg::line_addr_t i_wr_addr,

    input  wire                           i_rd_addr_valid,
    input  wire dram_traffic_pkg::line_addr_t i_rd_addr,

    input  wire                           i_mem_stall,
    input  wire                           i_writes_drained,
    input  wire                           i_has_space,

    output logic                          o_wr_ready,
    output logic                          o_rd_addr_ready,

    output logic                          o_mem_stb,
    output logic                          o_mem_we,
    output dram_traffic_pkg::line_addr_t  o_mem_addr,
    output dram_traffic_pkg::line_data_t  o_mem_wdata,

    output logic                          o_load_complete
);

    dram_traffic_pkg::traffic_state_t state;
    dram_traffic_pkg::traffic_state_t state_next;

    // the return buffer needs room for a stored line and a read in flight
    if (RETURN_DEPTH < 2) begin : g_depth_check
        $error("traffic_fsm: RETURN_DEPTH must be 2 or more");
    end

    always_comb begin
        state_next      = state;
        o_wr_ready      = 1'b0;
        o_rd_addr_ready = 1'b0;
        o_mem_stb       = 1'b0;
        o_mem_we        = 1'b0;
        o_mem_addr      = i_rd_addr;
        o_mem_wdata     = i_wr_data;  // only looked at with we high

        case (state)
            dram_traffic_pkg::ST_LOAD: begin
                o_wr_ready = !i_mem_stall;
                o_mem_stb  = i_wr_valid;
                o_mem_we   = 1'b1;
                o_mem_addr = i_wr_addr;  // next consecutive line
                if (i_wr_valid && !i_mem_stall && i_wr_last) begin
                    state_next = dram_traffic_pkg::ST_DRAIN;
                end
            end
            dram_traffic_pkg::ST_DRAIN: begin
                // no new traffic, just wait out the write acks
                if (i_writes_drained) begin
                    state_next = dram_traffic_pkg::ST_PLAY;
                end
            end
            dram_traffic_pkg::ST_PLAY: begin
                o_rd_addr_ready = !i_mem_stall && i_has_space;
                // hold stb off when no room, so a request always matches a beat
                o_mem_stb = i_rd_addr_valid && i_has_space;
            end
            default: begin
                state_next = dram_traffic_pkg::ST_LOAD;
            end
        endcase
    end

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            state           <= dram_traffic_pkg::ST_LOAD;
            o_load_complete <= 1'b0;
        end else begin
            state <= state_next;
            if (state == dram_traffic_pkg::ST_DRAIN && i_writes_drained) begin
                o_load_complete <= 1'b1;  // sticky until reset
            end
        end
    end

endmodule
`default_nettype wire

// ==== project.f ====
logic/dram_traffic_pkg.sv
logic/load_addr_counter.sv
logic/read_return_buffer.sv
logic/traffic_fsm.sv
logic/dram_traffic_top.sv
dv/dram_traffic_checker.sv
dv/tb_dram_memory.sv
dv/tb_dram_traffic.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the DRAM traffic arbiter testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module tb_dram_traffic -o sim_dram_traffic

./obj_dir/sim_dram_traffic +verilator+error+limit+100 | tee sim.log

if grep -q "^Testbench passed$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
